// File: common/cp0_config.svh
`ifndef CP0_CONFIG_SVH
`define CP0_CONFIG_SVH

`define CP0_DATA_W 32                     // Data and address width

// Register numbers, select 0 only
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15

`define CP0_VEC_BASE_BOOT   32'hBFC0_0200 // Used while BEV is set
`define CP0_VEC_BASE_NORMAL 32'h8000_0000
`define CP0_VEC_OFS_GENERAL 32'h0000_0180
`define CP0_VEC_OFS_SPECIAL 32'h0000_0200 // Interrupts with Cause IV set

`define CP0_PRID_VALUE 32'h0000_0001      // Revision 1

`define CP0_ST_CU0    28                  // Status fields
`define CP0_ST_BEV    22
`define CP0_ST_IM_HI  15
`define CP0_ST_IM_LO  8
`define CP0_ST_KSU_HI 4
`define CP0_ST_KSU_LO 3
`define CP0_ST_EXL    1
`define CP0_ST_IE     0
`define CP0_KSU_USER  2'b10

`define CP0_CA_BD     31                  // Cause fields
`define CP0_CA_IV     23
`define CP0_CA_IP_HI  15
`define CP0_CA_IP_LO  8
`define CP0_CA_EXC_HI 6
`define CP0_CA_EXC_LO 2

`endif

// File: common/cp0_pkg.sv
`include "cp0_config.svh"

package cp0_pkg;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,                   // Interrupt
        EXC_ADEL = 5'd4,                   // Address error on load or fetch
        EXC_ADES = 5'd5,                   // Address error on store
        EXC_IBE  = 5'd6,                   // Instruction bus error
        EXC_DBE  = 5'd7,                   // Data bus error
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,                  // Reserved instruction
        EXC_CPU  = 5'd11,                  // Coprocessor unusable
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13
    } exc_code_t;

    // Stage index into stall, flush and event stage
    localparam logic [1:0] STAGE_IF  = 2'd0;
    localparam logic [1:0] STAGE_ID  = 2'd1;
    localparam logic [1:0] STAGE_EX  = 2'd2;
    localparam logic [1:0] STAGE_MEM = 2'd3;

    typedef struct packed {
        logic [`CP0_DATA_W-1:0] pc;        // Restart PC of the stage
        logic                   is_bds;    // Branch delay slot
        logic                   source;    // May still raise an exception
    } stage_info_t;

    typedef struct packed {
        logic address_if;
        logic ibus_error;
        logic syscall;
        logic breakpoint;
        logic reserved;
        logic overflow;
        logic address_l_mem;
        logic address_s_mem;
        logic dbus_error;
        logic trap;
    } exc_flags_t;

    typedef struct packed {
        logic                   mfc0;
        logic                   mtc0;
        logic                   eret;
        logic [4:0]             reg_addr;
        logic [2:0]             sel;
        logic [`CP0_DATA_W-1:0] wdata;     // mtc0 data
    } cp0_access_t;

    typedef struct packed {
        logic [3:0] stall;                 // Index 0 IF up to 3 MEM
        logic [3:0] flush;
    } pipe_ctrl_t;

    typedef struct packed {
        logic                   take;      // Exception accepted this cycle
        logic [1:0]             stage;
        exc_code_t              code;
        logic [`CP0_DATA_W-1:0] pc;
        logic                   is_bds;
        logic [`CP0_DATA_W-1:0] bad_addr;
        logic                   bad_addr_valid;
        logic                   is_interrupt;
    } exc_event_t;

endpackage

// File: design/cp0_hazard.sv
`timescale 1ns/1ps
`include "cp0_config.svh"

module cp0_hazard (
    input  cp0_pkg::cp0_access_t   access,
    input  logic                   id_stall,
    input  cp0_pkg::exc_flags_t    exc,
    input  cp0_pkg::stage_info_t   if_info,
    input  cp0_pkg::stage_info_t   id_info,
    input  cp0_pkg::stage_info_t   ex_info,
    input  cp0_pkg::stage_info_t   mem_info,
    input  logic [`CP0_DATA_W-1:0] bad_address_if,
    input  logic [`CP0_DATA_W-1:0] bad_address_mem,
    input  logic                   id_is_flushed,
    input  logic                   kernel_mode,
    input  logic                   cu0,
    input  logic                   exl,
    input  logic                   irq_pending,
    output cp0_pkg::pipe_ctrl_t    ctrl,
    output cp0_pkg::exc_event_t    exc_event,
    output logic                   write_ok,
    output logic                   exception_ready
);
    logic       cp_unusable;               // CP0 op in user mode without CU0
    logic       irq_take;                  // Interrupt accepted at ID
    logic       eret_go;
    logic [3:0] exc_stage;                 // Raw exception per stage
    logic [3:0] mask;                      // Older stage may still fault
    logic [3:0] older;                     // Older stage faults now
    logic [3:0] ready;

    assign cp_unusable = (access.mfc0 | access.mtc0 | access.eret) & ~(cu0 | kernel_mode);
    assign irq_take    = irq_pending & ~exl & ~id_is_flushed;
    assign eret_go     = access.eret & ~id_stall;

    assign exc_stage[3] = exc.address_l_mem | exc.address_s_mem | exc.dbus_error | exc.trap;
    assign exc_stage[2] = exc.overflow;
    assign exc_stage[1] = exc.syscall | exc.breakpoint | exc.reserved | cp_unusable | irq_take;
    assign exc_stage[0] = exc.address_if | exc.ibus_error;

    assign mask[3] = 1'b0;                 // MEM is the oldest stage
    assign mask[2] = mem_info.source;
    assign mask[1] = mem_info.source | ex_info.source;
    assign mask[0] = mask[1] | id_info.source | irq_take; // Interrupt aborts the fetch

    assign older = {1'b0, exc_stage[3], |exc_stage[3:2], |exc_stage[3:1]};

    assign ready = exc_stage & ~mask & ~older; // Oldest unmasked fault only
    assign exception_ready = |ready;

    // Hold a masked fault until the older stages drain
    assign ctrl.stall[3] = exc_stage[3] & mask[3];
    assign ctrl.stall[2] = exc_stage[2] & mask[2] & ~older[2];
    assign ctrl.stall[1] = (exc_stage[1] | access.eret | access.mtc0) & mask[1] & ~older[1];
    assign ctrl.stall[0] = exc_stage[0] & mask[0] & ~older[0];

    // A held fault keeps its own stage alive
    assign ctrl.flush[3:1] = (exc_stage[3:1] & ~mask[3:1]) | older[3:1];
    assign ctrl.flush[0]   = (exc_stage[0] & ~mask[0]) | older[0] | eret_go; // Nothing after eret runs

    assign write_ok = access.mtc0 & ~id_stall & (cu0 | kernel_mode) & ~(|exc_stage);

    // Event of the ready stage, codes in priority order within the stage
    always_comb begin
        exc_event      = '0;
        exc_event.take = |ready;
        if (ready[3]) begin
            exc_event.stage          = cp0_pkg::STAGE_MEM;
            exc_event.pc             = mem_info.pc;
            exc_event.is_bds         = mem_info.is_bds;
            exc_event.bad_addr       = bad_address_mem;
            exc_event.bad_addr_valid = exc.address_l_mem | exc.address_s_mem;
            if (exc.address_l_mem)      exc_event.code = cp0_pkg::EXC_ADEL;
            else if (exc.address_s_mem) exc_event.code = cp0_pkg::EXC_ADES;
            else if (exc.dbus_error)    exc_event.code = cp0_pkg::EXC_DBE;
            else                        exc_event.code = cp0_pkg::EXC_TR;
        end else if (ready[2]) begin
            exc_event.stage  = cp0_pkg::STAGE_EX;
            exc_event.pc     = ex_info.pc;
            exc_event.is_bds = ex_info.is_bds;
            exc_event.code   = cp0_pkg::EXC_OV;
        end else if (ready[1]) begin
            exc_event.stage  = cp0_pkg::STAGE_ID;
            exc_event.pc     = id_info.pc;
            exc_event.is_bds = id_info.is_bds;
            if (exc.syscall)         exc_event.code = cp0_pkg::EXC_SYS;
            else if (exc.breakpoint) exc_event.code = cp0_pkg::EXC_BP;
            else if (exc.reserved)   exc_event.code = cp0_pkg::EXC_RI;
            else if (cp_unusable)    exc_event.code = cp0_pkg::EXC_CPU;
            else begin
                exc_event.code         = cp0_pkg::EXC_INT; // Interrupts come last
                exc_event.is_interrupt = 1'b1;
            end
        end else if (ready[0]) begin
            exc_event.stage          = cp0_pkg::STAGE_IF;
            exc_event.pc             = if_info.pc;
            exc_event.is_bds         = if_info.is_bds;
            exc_event.bad_addr       = bad_address_if;
            exc_event.bad_addr_valid = exc.address_if;
            exc_event.code = exc.address_if ? cp0_pkg::EXC_ADEL : cp0_pkg::EXC_IBE;
        end
    end

    always_comb begin
        a_one_ready: assert final ($onehot0(ready))
            else $error("cp0_hazard: more than one stage ready %b", ready);
    end

endmodule

// File: design/cp0_timer.sv
`timescale 1ns/1ps
`include "cp0_config.svh"

module cp0_timer (
    input  logic                   clk,
    input  logic                   rst,
    input  cp0_pkg::cp0_access_t   access,
    input  logic                   count_write,   // mtc0 to Count
    input  logic                   timer_clear,   // mtc0 to Compare
    input  logic                   im7,
    output logic [`CP0_DATA_W-1:0] count_value,
    output logic [`CP0_DATA_W-1:0] compare_value,
    output logic                   timer_irq
);
    logic match;

    assign match = (count_value == compare_value) & im7;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_value   <= '0;
            compare_value <= '0;
            timer_irq     <= 1'b0;
        end else begin
            count_value <= count_write ? access.wdata : count_value + 1'b1; // Free running
            if (timer_clear) begin
                compare_value <= access.wdata;
                timer_irq     <= 1'b0;                // Compare write acks the interrupt
            end else if (match) begin
                timer_irq <= 1'b1;                    // Sticky until acked
            end
        end
    end

    a_clear_wins: assert property (@(posedge clk) disable iff (rst) timer_clear |=> !timer_irq)
        else $error("cp0_timer: timer_irq set right after Compare write");

endmodule

// File: design/cp0_regs.sv
`timescale 1ns/1ps
`include "cp0_config.svh"

module cp0_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  cp0_pkg::cp0_access_t   access,
    input  logic                   id_stall,
    input  logic [4:0]             interrupts,
    input  cp0_pkg::exc_event_t    exc_event,
    input  logic                   write_ok,
    input  logic                   timer_irq,
    input  logic [`CP0_DATA_W-1:0] count_value,
    input  logic [`CP0_DATA_W-1:0] compare_value,
    output logic [`CP0_DATA_W-1:0] rdata,
    output logic                   kernel_mode,
    output logic                   cu0,
    output logic                   exl,
    output logic                   irq_pending,
    output logic                   count_write,
    output logic                   timer_clear,
    output logic                   im7,
    output logic                   exception_pc_select,
    output logic [`CP0_DATA_W-1:0] pc_exception
);
    logic                   bev;
    logic [7:0]             im;
    logic [1:0]             ksu;
    logic                   ie;
    logic                   bd;
    logic                   iv;
    logic [4:0]             ip_hw;         // External lines, one cycle late
    logic [1:0]             ip_sw;         // Software interrupts
    cp0_pkg::exc_code_t     exc_code;
    logic [`CP0_DATA_W-1:0] epc;
    logic [`CP0_DATA_W-1:0] badvaddr;
    logic [7:0]             ip;
    logic [`CP0_DATA_W-1:0] status_word;
    logic [`CP0_DATA_W-1:0] cause_word;
    logic [`CP0_DATA_W-1:0] vec_base;
    logic                   wr_sel0;
    logic                   wr_status;
    logic                   wr_cause;
    logic                   wr_epc;
    logic                   eret_go;

    assign ip          = {timer_irq, ip_hw, ip_sw};
    assign kernel_mode = (ksu != `CP0_KSU_USER) | exl; // EXL forces kernel
    assign irq_pending = ie & |(ip & im);
    assign im7         = im[7];
    assign eret_go     = access.eret & ~id_stall;

    assign wr_sel0     = write_ok & (access.sel == 3'd0);
    assign wr_status   = wr_sel0 & (access.reg_addr == `CP0_REG_STATUS);
    assign wr_cause    = wr_sel0 & (access.reg_addr == `CP0_REG_CAUSE);
    assign wr_epc      = wr_sel0 & (access.reg_addr == `CP0_REG_EPC);
    assign count_write = wr_sel0 & (access.reg_addr == `CP0_REG_COUNT);
    assign timer_clear = wr_sel0 & (access.reg_addr == `CP0_REG_COMPARE);

    always_ff @(posedge clk) begin
        if (rst) begin
            cu0      <= 1'b0;
            bev      <= 1'b1;                  // Boot vectors out of reset
            im       <= '0;
            ksu      <= 2'b00;                 // Kernel
            exl      <= 1'b0;
            ie       <= 1'b0;
            bd       <= 1'b0;
            iv       <= 1'b0;
            ip_hw    <= '0;
            ip_sw    <= '0;
            exc_code <= cp0_pkg::EXC_INT;
        end else begin
            ip_hw <= interrupts;
            if (exc_event.take) begin
                exl      <= 1'b1;
                exc_code <= exc_event.code;
                if (!exl) bd <= exc_event.is_bds; // Nested fault keeps first BD
            end else begin
                if (wr_status) begin
                    cu0 <= access.wdata[`CP0_ST_CU0];
                    bev <= access.wdata[`CP0_ST_BEV];
                    im  <= access.wdata[`CP0_ST_IM_HI:`CP0_ST_IM_LO];
                    ksu <= access.wdata[`CP0_ST_KSU_HI:`CP0_ST_KSU_LO];
                    exl <= access.wdata[`CP0_ST_EXL];
                    ie  <= access.wdata[`CP0_ST_IE];
                end else if (eret_go) begin
                    exl <= 1'b0;               // Back to previous level
                end
                if (wr_cause) begin
                    iv    <= access.wdata[`CP0_CA_IV];
                    ip_sw <= access.wdata[`CP0_CA_IP_LO+1:`CP0_CA_IP_LO];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_event.take) begin
            if (!exl) epc <= exc_event.pc;
            if (exc_event.bad_addr_valid) badvaddr <= exc_event.bad_addr;
        end else if (wr_epc) begin
            epc <= access.wdata;
        end
    end

    always_comb begin
        status_word                                 = '0;
        status_word[`CP0_ST_CU0]                    = cu0;
        status_word[`CP0_ST_BEV]                    = bev;
        status_word[`CP0_ST_IM_HI:`CP0_ST_IM_LO]    = im;
        status_word[`CP0_ST_KSU_HI:`CP0_ST_KSU_LO]  = ksu;
        status_word[`CP0_ST_EXL]                    = exl;
        status_word[`CP0_ST_IE]                     = ie;
        cause_word                                  = '0;
        cause_word[`CP0_CA_BD]                      = bd;
        cause_word[`CP0_CA_IV]                      = iv;
        cause_word[`CP0_CA_IP_HI:`CP0_CA_IP_LO]     = ip;
        cause_word[`CP0_CA_EXC_HI:`CP0_CA_EXC_LO]   = exc_code;
    end

    // Read mux, zero when unusable or unmapped
    always_comb begin
        rdata = '0;
        if (access.mfc0 && (cu0 || kernel_mode) && access.sel == 3'd0) begin
            case (access.reg_addr)
                `CP0_REG_BADVADDR: rdata = badvaddr;
                `CP0_REG_COUNT:    rdata = count_value;
                `CP0_REG_COMPARE:  rdata = compare_value;
                `CP0_REG_STATUS:   rdata = status_word;
                `CP0_REG_CAUSE:    rdata = cause_word;
                `CP0_REG_EPC:      rdata = epc;
                `CP0_REG_PRID:     rdata = `CP0_PRID_VALUE;
                default:           rdata = '0;
            endcase
        end
    end

    assign vec_base = bev ? `CP0_VEC_BASE_BOOT : `CP0_VEC_BASE_NORMAL;

    always_comb begin
        if (eret_go)
            pc_exception = epc;
        else if (exc_event.is_interrupt && iv)
            pc_exception = vec_base + `CP0_VEC_OFS_SPECIAL; // Dedicated interrupt entry
        else
            pc_exception = vec_base + `CP0_VEC_OFS_GENERAL;
    end

    assign exception_pc_select = rst | eret_go | exc_event.take;

    a_no_write_on_take: assert property (@(posedge clk) disable iff (rst)
        exc_event.take |-> !write_ok)
        else $error("cp0_regs: exception capture together with mtc0");

endmodule

// File: design/cp0_top.sv
`timescale 1ns/1ps
`include "cp0_config.svh"

module cp0_top (
    input  logic                   clk,
    input  logic                   rst,
    input  cp0_pkg::cp0_access_t   access,         // CP0 op at ID
    input  logic                   id_stall,
    input  cp0_pkg::exc_flags_t    exc,
    input  cp0_pkg::stage_info_t   if_info,
    input  cp0_pkg::stage_info_t   id_info,
    input  cp0_pkg::stage_info_t   ex_info,
    input  cp0_pkg::stage_info_t   mem_info,
    input  logic [`CP0_DATA_W-1:0] bad_address_if,
    input  logic [`CP0_DATA_W-1:0] bad_address_mem,
    input  logic [4:0]             interrupts,     // External lines
    input  logic                   id_is_flushed,
    output logic [`CP0_DATA_W-1:0] rdata,
    output logic                   kernel_mode,
    output cp0_pkg::pipe_ctrl_t    ctrl,
    output logic                   exception_ready,
    output logic                   exception_pc_select,
    output logic [`CP0_DATA_W-1:0] pc_exception
);
    logic                   cu0;
    logic                   exl;
    logic                   irq_pending;
    cp0_pkg::exc_event_t    exc_event;
    logic                   write_ok;
    logic                   timer_irq;
    logic                   timer_clear;
    logic                   count_write;
    logic                   im7;
    logic [`CP0_DATA_W-1:0] count_value;
    logic [`CP0_DATA_W-1:0] compare_value;

    cp0_hazard u_hazard (
        .access          (access),
        .id_stall        (id_stall),
        .exc             (exc),
        .if_info         (if_info),
        .id_info         (id_info),
        .ex_info         (ex_info),
        .mem_info        (mem_info),
        .bad_address_if  (bad_address_if),
        .bad_address_mem (bad_address_mem),
        .id_is_flushed   (id_is_flushed),
        .kernel_mode     (kernel_mode),
        .cu0             (cu0),
        .exl             (exl),
        .irq_pending     (irq_pending),
        .ctrl            (ctrl),
        .exc_event       (exc_event),
        .write_ok        (write_ok),
        .exception_ready (exception_ready)
    );

    cp0_regs u_regs (
        .clk                 (clk),
        .rst                 (rst),
        .access              (access),
        .id_stall            (id_stall),
        .interrupts          (interrupts),
        .exc_event           (exc_event),
        .write_ok            (write_ok),
        .timer_irq           (timer_irq),
        .count_value         (count_value),
        .compare_value       (compare_value),
        .rdata               (rdata),
        .kernel_mode         (kernel_mode),
        .cu0                 (cu0),
        .exl                 (exl),
        .irq_pending         (irq_pending),
        .count_write         (count_write),
        .timer_clear         (timer_clear),
        .im7                 (im7),
        .exception_pc_select (exception_pc_select),
        .pc_exception        (pc_exception)
    );

    cp0_timer u_timer (
        .clk           (clk),
        .rst           (rst),
        .access        (access),
        .count_write   (count_write),
        .timer_clear   (timer_clear),
        .im7           (im7),
        .count_value   (count_value),
        .compare_value (compare_value),
        .timer_irq     (timer_irq)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;            // 100 ns period
    end

endmodule

// File: bench/tb_cp0.sv
`timescale 1ns/1ps
`include "cp0_config.svh"

module tb_cp0;
    localparam logic [31:0] status_writable = (32'd1 << `CP0_ST_CU0) | (32'd1 << `CP0_ST_BEV)
        | (32'hFF << `CP0_ST_IM_LO) | (32'd3 << `CP0_ST_KSU_LO) | (32'd1 << `CP0_ST_EXL)
        | (32'd1 << `CP0_ST_IE);
    localparam logic [31:0] status_mode  = (32'd3 << `CP0_ST_KSU_LO) | (32'd1 << `CP0_ST_EXL)
        | (32'd1 << `CP0_ST_IE);           // Kept clear in random Status data
    localparam logic [31:0] status_bev   = 32'd1 << `CP0_ST_BEV;
    localparam logic [31:0] status_im7   = 32'd1 << `CP0_ST_IM_HI;
    localparam logic [31:0] status_ie    = 32'd1 << `CP0_ST_IE;
    localparam logic [31:0] general_boot = `CP0_VEC_BASE_BOOT + `CP0_VEC_OFS_GENERAL;

    logic                   clk;
    logic                   rst;
    cp0_pkg::cp0_access_t   access;
    logic                   id_stall;
    cp0_pkg::exc_flags_t    exc;
    cp0_pkg::stage_info_t   if_info;
    cp0_pkg::stage_info_t   id_info;
    cp0_pkg::stage_info_t   ex_info;
    cp0_pkg::stage_info_t   mem_info;
    logic [`CP0_DATA_W-1:0] bad_address_if;
    logic [`CP0_DATA_W-1:0] bad_address_mem;
    logic [4:0]             interrupts;
    logic                   id_is_flushed;
    logic [`CP0_DATA_W-1:0] rdata;
    logic                   kernel_mode;
    cp0_pkg::pipe_ctrl_t    ctrl;
    logic                   exception_ready;
    logic                   exception_pc_select;
    logic [`CP0_DATA_W-1:0] pc_exception;

    logic                   chk_rdata;     // Expected responses, set with the stimulus
    logic [31:0]            exp_rdata;
    logic                   chk_ctrl;
    cp0_pkg::pipe_ctrl_t    exp_ctrl;
    logic                   exp_ready;
    logic                   chk_pc;
    logic [31:0]            exp_pc;

    integer                 seed;
    integer                 wait_cycles;
    logic [31:0]            epc_data;
    logic [31:0]            compare_data;
    logic [31:0]            status_raw;
    logic [31:0]            status_data;
    logic [31:0]            mem_pc;
    logic [31:0]            bad_addr;
    logic [31:0]            count_data;

    tb_clock u_clock (.clk(clk));

    cp0_top u_cp0_top (
        .clk                 (clk),
        .rst                 (rst),
        .access              (access),
        .id_stall            (id_stall),
        .exc                 (exc),
        .if_info             (if_info),
        .id_info             (id_info),
        .ex_info             (ex_info),
        .mem_info            (mem_info),
        .bad_address_if      (bad_address_if),
        .bad_address_mem     (bad_address_mem),
        .interrupts          (interrupts),
        .id_is_flushed       (id_is_flushed),
        .rdata               (rdata),
        .kernel_mode         (kernel_mode),
        .ctrl                (ctrl),
        .exception_ready     (exception_ready),
        .exception_pc_select (exception_pc_select),
        .pc_exception        (pc_exception)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
    endtask

    function automatic logic [31:0] expected_cause(input logic [7:0] ip, input logic [4:0] code);
        logic [31:0] word;
        word                                     = '0;
        word[`CP0_CA_IP_HI:`CP0_CA_IP_LO]        = ip;
        word[`CP0_CA_EXC_HI:`CP0_CA_EXC_LO]      = code;
        return word;
    endfunction

    // Quiet pipeline, no stall, flush or ready expected
    task automatic idle_inputs;
        access          = '0;
        id_stall        = 1'b0;
        exc             = '0;
        if_info         = '0;
        id_info         = '0;
        ex_info         = '0;
        mem_info        = '0;
        bad_address_if  = '0;
        bad_address_mem = '0;
        interrupts      = '0;
        id_is_flushed   = 1'b0;
        chk_rdata       = 1'b0;
        exp_rdata       = '0;
        chk_ctrl        = 1'b1;
        exp_ctrl        = '0;
        exp_ready       = 1'b0;
        chk_pc          = 1'b0;
        exp_pc          = '0;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        idle_inputs();
        access.mtc0     = 1'b1;
        access.reg_addr = addr;
        access.wdata    = data;
    endtask

    task automatic read_expect(input logic [4:0] addr, input logic [31:0] want);
        @(negedge clk);
        idle_inputs();
        access.mfc0     = 1'b1;
        access.reg_addr = addr;
        chk_rdata       = 1'b1;
        exp_rdata       = want;
    endtask

    a_rdata: assert property (@(posedge clk) disable iff (rst) chk_rdata |-> rdata == exp_rdata)
        else report_mismatch("rdata", $sampled(rdata), $sampled(exp_rdata));
    a_ctrl: assert property (@(posedge clk) disable iff (rst) chk_ctrl |-> ctrl == exp_ctrl)
        else report_mismatch("ctrl", $sampled(ctrl), $sampled(exp_ctrl));
    a_ready: assert property (@(posedge clk) disable iff (rst)
        chk_ctrl |-> exception_ready == exp_ready)
        else report_mismatch("exception_ready", $sampled(exception_ready), $sampled(exp_ready));
    a_pc_select: assert property (@(posedge clk) disable iff (rst)
        exception_pc_select == chk_pc)
        else report_mismatch("exception_pc_select", $sampled(exception_pc_select),
                             $sampled(chk_pc));
    a_pc: assert property (@(posedge clk) disable iff (rst) chk_pc |-> pc_exception == exp_pc)
        else report_mismatch("pc_exception", $sampled(pc_exception), $sampled(exp_pc));
    a_kernel: assert property (@(posedge clk) disable iff (rst) kernel_mode) // KSU never user
        else report_mismatch("kernel_mode", $sampled(kernel_mode), 32'd1);
    a_rst_select: assert property (@(posedge clk) rst |-> exception_pc_select)
        else report_mismatch("exception_pc_select", $sampled(exception_pc_select), 32'd1);

    initial begin
        seed = 32'h8f48_d4d6;
        rst  = 1'b1;
        idle_inputs();
        repeat (8) @(negedge clk);
        rst = 1'b0;

        read_expect(`CP0_REG_STATUS, status_bev); // BEV set, kernel, EXL clear

        epc_data     = $random(seed);
        compare_data = $random(seed);
        status_raw   = ($random(seed) & ~status_mode) | status_bev;
        status_data  = status_raw & status_writable;
        write_reg(`CP0_REG_EPC, epc_data);
        read_expect(`CP0_REG_EPC, epc_data);
        write_reg(`CP0_REG_COMPARE, compare_data);
        read_expect(`CP0_REG_COMPARE, compare_data);
        write_reg(`CP0_REG_STATUS, status_raw);
        read_expect(`CP0_REG_STATUS, status_data);
        read_expect(`CP0_REG_PRID, `CP0_PRID_VALUE);

        // MEM address error beats ID syscall
        mem_pc   = $random(seed) & ~32'h3;
        bad_addr = $random(seed);
        @(negedge clk);
        idle_inputs();
        exc.address_l_mem = 1'b1;
        exc.syscall       = 1'b1;
        mem_info.pc       = mem_pc;
        bad_address_mem   = bad_addr;
        exp_ready         = 1'b1;
        exp_ctrl.flush    = 4'b1111;
        chk_pc            = 1'b1;
        exp_pc            = general_boot;
        read_expect(`CP0_REG_CAUSE, expected_cause(8'h00, cp0_pkg::EXC_ADEL));
        read_expect(`CP0_REG_EPC, mem_pc);
        read_expect(`CP0_REG_BADVADDR, bad_addr);

        // Syscall held while EX may still fault
        @(negedge clk);
        idle_inputs();
        exc.syscall    = 1'b1;
        id_info.pc     = $random(seed) & ~32'h3;
        ex_info.source = 1'b1;
        exp_ctrl.stall = 4'b0010;
        exp_ctrl.flush = 4'b0001;          // Held syscall stays in ID
        @(negedge clk);
        ex_info.source = 1'b0;
        exp_ctrl.stall = 4'b0000;
        exp_ctrl.flush = 4'b0011;          // Own stage and younger
        exp_ready      = 1'b1;
        chk_pc         = 1'b1;
        exp_pc         = general_boot;
        read_expect(`CP0_REG_CAUSE, expected_cause(8'h00, cp0_pkg::EXC_SYS));
        read_expect(`CP0_REG_EPC, mem_pc); // EXL already set, EPC kept

        @(negedge clk);
        idle_inputs();
        access.eret    = 1'b1;
        exp_ctrl.flush = 4'b0001;
        chk_pc         = 1'b1;
        exp_pc         = mem_pc;
        read_expect(`CP0_REG_STATUS, status_data); // EXL back to 0

        // Timer match a few cycles ahead
        count_data = 32'h0000_1000 | ($random(seed) & 32'h0000_0FF0);
        write_reg(`CP0_REG_COUNT, count_data);
        write_reg(`CP0_REG_COMPARE, count_data + 32'd12);
        write_reg(`CP0_REG_STATUS, status_bev | status_im7 | status_ie);
        @(negedge clk);
        idle_inputs();
        chk_ctrl    = 1'b0;
        wait_cycles = 0;
        while (!exception_ready && wait_cycles < 64) begin
            @(negedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (!exception_ready) begin
            abort_run("timeout waiting for the timer interrupt");
        end else begin
            chk_ctrl       = 1'b1;
            exp_ready      = 1'b1;
            exp_ctrl.flush = 4'b0011;      // Taken at ID
            chk_pc         = 1'b1;
            exp_pc         = general_boot;
            read_expect(`CP0_REG_CAUSE, expected_cause(8'h80, cp0_pkg::EXC_INT));
            write_reg(`CP0_REG_COMPARE, count_data + 32'h0001_0000);
            read_expect(`CP0_REG_CAUSE, expected_cause(8'h00, cp0_pkg::EXC_INT));
            @(negedge clk);
            idle_inputs();
            @(negedge clk);
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+common
common/cp0_pkg.sv
design/cp0_hazard.sv
design/cp0_timer.sv
design/cp0_regs.sv
design/cp0_top.sv
bench/tb_clock.sv
bench/tb_cp0.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_cp0
FILELIST   := verilog.f
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
